// File: trig_top.f
+incdir+hw
hw/trig_pkg.sv
hw/trig_csr_ctrl.sv
hw/trig_bank.sv
hw/trig_match.sv
hw/trig_top.sv
testbench/trig_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the trigger unit testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
set -o pipefail
log=sim.log

verilator --binary --timing --timescale 1ns/10ps -f trig_top.f \
	--top-module trig_tb -o trig_sim \
	&& ./obj_dir/trig_sim 2>&1 | tee "$log" \
	|| { echo "simulation build or run failed"; exit 1; }

grep -q "Test FAILED" "$log" && { echo "simulation reported a failure"; exit 1; }
grep -q "Test OK" "$log" || { echo "simulation ended without a verdict"; exit 1; }
exit 0

// File: testbench/trig_tb.sv
// self-checking trigger unit testbench that checks random CSR and fetch traffic against a model
`timescale 1ns/10ps

`include "trig_defines.svh"

module trig_tb;

	import trig_pkg::*;

	localparam int NUM_OPS = 2000;
	// every op takes one cycle and the limit leaves a generous margin
	localparam int CYCLE_LIMIT = 4 * NUM_OPS + 100;

	logic clk;
	logic rst_n;
	cfg_req_t cfg;
	logic x_d_mode;
	logic trig_m_en;
	fetch_query_t fetch;
	xlen_t cfg_rdata;
	break_req_t brk;

	integer seed;
	int cycles;
	int blocked_writes;
	int break_hits;

	// reference model state
	tsel_t model_tsel;
	trig_cfg_t model_cfg [0:`TRIG_NUM-1];

	trig_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.cfg_rdata(cfg_rdata),
		.x_d_mode(x_d_mode),
		.trig_m_en(trig_m_en),
		.fetch(fetch),
		.brk(brk)
	);

	// --------------------------------------------------
	// clock and cycle limit

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	// --------------------------------------------------
	// compare tasks

	task automatic check_word(input string name, input xlen_t expected, input xlen_t actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %h got %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_brk(input string name, input break_req_t expected,
		input break_req_t actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %h got %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "break request mismatch");
		end
	endtask

	// --------------------------------------------------
	// reference model

	function automatic logic tsel_ok();
		return (int'(model_tsel) < `TRIG_NUM);
	endfunction

	// read word for a CSR number from the model's current state
	function automatic xlen_t expected_rdata(input csr_addr_t addr);
		xlen_t word;
		trig_cfg_t t;
		word = '0;
		t = model_cfg[model_tsel];
		if (addr == `CSR_TSELECT) begin
			word = xlen_t'(model_tsel);
		end else if (addr == `CSR_TDATA1) begin
			// mcontrol layout with type 2 in the top nibble
			if (tsel_ok()) begin
				word[31:28] = 4'd2;
				word[27] = t.dmode;
				word[12] = t.action;
				word[6] = t.m;
				word[3] = t.u;
				word[2] = t.execute;
			end
		end else if (addr == `CSR_TDATA2) begin
			if (tsel_ok()) begin
				word = t.tdata2;
			end
		end else if (addr == `CSR_TINFO) begin
			word = tsel_ok() ? xlen_t'(`TINFO_MCONTROL) : xlen_t'(`TINFO_NONE);
		end
		return word;
	endfunction

	// break rule applied trigger by trigger
	function automatic break_req_t expected_brk(input fetch_query_t f, input logic m_en);
		break_req_t b;
		logic armed;
		logic hit;
		int hw;
		b = '0;
		for (int i = 0; i < `TRIG_NUM; i++) begin
			armed = model_cfg[i].execute && !f.d_mode &&
				(f.m_mode ? model_cfg[i].m : model_cfg[i].u);
			hit = armed && (f.addr[31:2] == model_cfg[i].tdata2[31:2]);
			hw = model_cfg[i].tdata2[1] ? 1 : 0;
			if (hit && model_cfg[i].action && model_cfg[i].dmode) begin
				b.d_mode[hw] = 1'b1;
				b.any[hw] = 1'b1;
			end else if (hit && !model_cfg[i].action && m_en) begin
				b.any[hw] = 1'b1;
			end
		end
		return b;
	endfunction

	// write rules as the rising edge applies them
	task automatic update_model(input cfg_req_t c, input logic xd);
		if (c.wen) begin
			if (c.addr == `CSR_TSELECT) begin
				model_tsel = c.wdata[`TRIG_TSEL_W-1:0];
			end else if (tsel_ok() && (!model_cfg[model_tsel].dmode || xd)) begin
				if (c.addr == `CSR_TDATA1) begin
					model_cfg[model_tsel].action = c.wdata[12];
					model_cfg[model_tsel].m = c.wdata[6];
					model_cfg[model_tsel].u = c.wdata[3];
					model_cfg[model_tsel].execute = c.wdata[2];
					if (xd) begin
						model_cfg[model_tsel].dmode = c.wdata[27];
					end
				end else if (c.addr == `CSR_TDATA2) begin
					model_cfg[model_tsel].tdata2 = c.wdata;
				end
			end else if (c.addr == `CSR_TDATA1 || c.addr == `CSR_TDATA2) begin
				blocked_writes++;
			end
		end
	endtask

	// --------------------------------------------------
	// stimulus

	// a few word addresses shared by tdata2 and fetch so hits are common
	function automatic xlen_t pool_word(input logic [1:0] k);
		case (k)
			2'd0: return 32'h8000_0000;
			2'd1: return 32'h8000_0004;
			2'd2: return 32'h8000_0100;
			default: return 32'h0000_1000;
		endcase
	endfunction

	// one cycle that drives on the falling edge and checks just before the rising edge
	task automatic run_op(input cfg_req_t c, input logic xd, input logic men,
		input fetch_query_t f);
		xlen_t exp_rdata;
		break_req_t exp_brk;
		@(negedge clk);
		cfg = c;
		x_d_mode = xd;
		trig_m_en = men;
		fetch = f;
		#4;
		exp_rdata = expected_rdata(c.addr);
		exp_brk = expected_brk(f, men);
		check_word("cfg_rdata", exp_rdata, cfg_rdata);
		check_brk("brk", exp_brk, brk);
		if (exp_brk.any != 2'b00) begin
			break_hits++;
		end
		update_model(c, xd);
	endtask

	// CSR write outside debug mode with an idle fetch alongside
	task automatic write_csr(input csr_addr_t addr, input xlen_t data);
		cfg_req_t c;
		fetch_query_t f;
		c.addr = addr;
		c.wen = 1'b1;
		c.wdata = data;
		f = '0;
		run_op(c, 1'b0, 1'b1, f);
	endtask

	// fetch query with M-mode breaks enabled and no CSR write
	task automatic fetch_word(input xlen_t addr, input logic m_mode, input logic d_mode);
		cfg_req_t c;
		fetch_query_t f;
		c = '0;
		f.addr = addr;
		f.m_mode = m_mode;
		f.d_mode = d_mode;
		run_op(c, 1'b0, 1'b1, f);
	endtask

	task automatic random_op();
		cfg_req_t c;
		fetch_query_t f;
		logic xd;
		logic men;
		xlen_t r;
		xlen_t pick;
		int k;
		r = $random(seed);
		case (r[2:0])
			3'd0: c.addr = `CSR_TSELECT;
			3'd1, 3'd2: c.addr = `CSR_TDATA1;
			3'd3, 3'd4: c.addr = `CSR_TDATA2;
			3'd5: c.addr = `CSR_TINFO;
			3'd6: c.addr = 12'h7a3;
			default: c.addr = r[15:4];
		endcase
		c.wen = r[16];
		// debug mode on about a quarter of the cycles
		xd = (r[18:17] == 2'b11);
		men = r[19];
		c.wdata = $random(seed);
		if (c.addr == `CSR_TDATA1 && r[20]) begin
			c.wdata[2] = 1'b1;
		end
		if (c.addr == `CSR_TDATA2 && r[22:21] != 2'b00) begin
			c.wdata = pool_word(r[24:23]) | {30'b0, r[26:25]};
		end
		pick = $random(seed);
		k = int'(pick[7:4]) % `TRIG_NUM;
		// half the fetches aim at a loaded tdata2
		case (pick[1:0])
			2'd0, 2'd1: f.addr = {model_cfg[k].tdata2[31:2], 2'b00};
			2'd2: f.addr = pool_word(pick[9:8]);
			default: f.addr = {pick[31:12], pick[11:10], 10'b0};
		endcase
		f.m_mode = pick[2];
		f.d_mode = (pick[3] && pick[8] && pick[9]);
		run_op(c, xd, men, f);
	endtask

	// --------------------------------------------------
	// main sequence

	initial begin
		cfg_req_t c;
		fetch_query_t f;
		xlen_t r;
		seed = 32'hcacf_27c3;
		cycles = 0;
		blocked_writes = 0;
		break_hits = 0;
		rst_n = 1'b0;
		cfg = '0;
		x_d_mode = 1'b0;
		trig_m_en = 1'b0;
		fetch = '0;
		model_tsel = '0;
		for (int i = 0; i < `TRIG_NUM; i++) begin
			model_cfg[i] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// reset values of all four CSRs with random fetches alongside
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			c = '0;
			c.addr = (i == 0) ? `CSR_TSELECT : (i == 1) ? `CSR_TDATA1 :
				(i == 2) ? `CSR_TDATA2 : `CSR_TINFO;
			f.addr = {r[31:2], 2'b00};
			f.m_mode = r[0];
			f.d_mode = 1'b0;
			run_op(c, 1'b0, 1'b1, f);
		end

		// two M-mode execute triggers on the two halfwords of one word
		write_csr(`CSR_TSELECT, 32'd0);
		write_csr(`CSR_TDATA1, 32'h0000_0044);
		write_csr(`CSR_TDATA2, 32'h8000_0000);
		write_csr(`CSR_TSELECT, 32'd1);
		write_csr(`CSR_TDATA1, 32'h0000_0044);
		write_csr(`CSR_TDATA2, 32'h8000_0002);
		fetch_word(32'h8000_0000, 1'b1, 1'b0);
		// the same word fetched from debug mode stays quiet
		fetch_word(32'h8000_0000, 1'b1, 1'b1);

		for (int n = 0; n < NUM_OPS; n++) begin
			random_op();
		end

		$display("ops %0d, blocked writes %0d, cycles with a break %0d",
			NUM_OPS, blocked_writes, break_hits);
		$display("Test OK");
		$finish;
	end

endmodule

// File: hw/trig_top.sv
// top level of the breakpoint trigger unit, joins CSR control, trigger bank and fetch matcher
`timescale 1ns/10ps

`include "trig_defines.svh"

module trig_top (
	input logic clk,
	input logic rst_n,

	// debug CSR port, combinational read, registered write
	input trig_pkg::cfg_req_t cfg,
	output trig_pkg::xlen_t cfg_rdata,

	// debug mode flag of the executing instruction, for CSR protection
	input logic x_d_mode,

	// global enable for breaks to M-mode
	input logic trig_m_en,

	// fetch query and its break request, same cycle
	input trig_pkg::fetch_query_t fetch,
	output trig_pkg::break_req_t brk
);

	import trig_pkg::*;

	// --------------------------------------------------
	// internal nets

	bank_wr_t bank_wr;
	trig_cfg_t sel_cfg;
	trig_cfg_t [`TRIG_NUM-1:0] all_cfg;

	// --------------------------------------------------
	// instances

	// CSR decode, tselect and write guard
	trig_csr_ctrl u_csr_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.x_d_mode(x_d_mode),
		.sel_cfg(sel_cfg),
		.bank_wr(bank_wr),
		.cfg_rdata(cfg_rdata)
	);

	// per-trigger state
	trig_bank u_bank (
		.clk(clk),
		.rst_n(rst_n),
		.bank_wr(bank_wr),
		.sel_cfg(sel_cfg),
		.all_cfg(all_cfg)
	);

	// fetch address compare
	trig_match u_match (
		.all_cfg(all_cfg),
		.fetch(fetch),
		.trig_m_en(trig_m_en),
		.brk(brk)
	);

endmodule

// File: hw/trig_match.sv
// fetch address matcher, checks one fetch word against all triggers and raises per-halfword breaks
`timescale 1ns/10ps

`include "trig_defines.svh"

module trig_match (
	input trig_pkg::trig_cfg_t [`TRIG_NUM-1:0] all_cfg,
	input trig_pkg::fetch_query_t fetch,
	input logic trig_m_en,
	output trig_pkg::break_req_t brk
);

	import trig_pkg::*;

	// per-trigger intermediate results
	logic [`TRIG_NUM-1:0] trig_en;
	logic [`TRIG_NUM-1:0] trig_hit;
	logic [`TRIG_NUM-1:0] d_brk;
	logic [`TRIG_NUM-1:0] m_brk;

	// reduced over all triggers, per halfword
	hw_flags_t d_flags;
	hw_flags_t m_flags;

	// --------------------------------------------------
	// per-trigger hit and break kind

	always_comb begin
		for (int i = 0; i < `TRIG_NUM; i++) begin
			// execute trigger armed for the fetch's privilege
			// debug mode fetches are never checked
			trig_en[i] = all_cfg[i].execute && !fetch.d_mode &&
				(fetch.m_mode ? all_cfg[i].m : all_cfg[i].u);
			// exact word compare, fetches are always word aligned
			trig_hit[i] = trig_en[i] &&
				(fetch.addr == {all_cfg[i].tdata2[`TRIG_XLEN-1:2], 2'b00});
			// action 1 enters debug mode, only allowed for a dmode trigger
			d_brk[i] = trig_hit[i] && all_cfg[i].action && all_cfg[i].dmode;
			// action 0 raises a breakpoint exception, gated by the global enable
			m_brk[i] = trig_hit[i] && !all_cfg[i].action && trig_m_en;
		end
	end

	// --------------------------------------------------
	// halfword split and reduction

	// bit 1 of tdata2 tells which halfword of the word the breakpoint sits on
	// two triggers may flag different halfwords of the same word
	always_comb begin
		d_flags = '0;
		m_flags = '0;
		for (int i = 0; i < `TRIG_NUM; i++) begin
			if (all_cfg[i].tdata2[1]) begin
				d_flags[1] = d_flags[1] | d_brk[i];
				m_flags[1] = m_flags[1] | m_brk[i];
			end else begin
				d_flags[0] = d_flags[0] | d_brk[i];
				m_flags[0] = m_flags[0] | m_brk[i];
			end
		end
	end

	// any break of either kind, plus the debug-mode subset
	assign brk = '{any: d_flags | m_flags, d_mode: d_flags};

endmodule

// File: hw/trig_bank.sv
// trigger configuration storage, one indexed write port and a read port for the indexed entry
`timescale 1ns/10ps

`include "trig_defines.svh"

module trig_bank (
	input logic clk,
	input logic rst_n,
	input trig_pkg::bank_wr_t bank_wr,
	output trig_pkg::trig_cfg_t sel_cfg,
	output trig_pkg::trig_cfg_t [`TRIG_NUM-1:0] all_cfg
);

	import trig_pkg::*;

	// every trigger's state, entry i is trigger i
	trig_cfg_t [`TRIG_NUM-1:0] cfg_q;
	// one-hot entry select decoded from the write index
	logic [`TRIG_NUM-1:0] entry_sel;

	// --------------------------------------------------
	// index decode

	always_comb begin
		for (int i = 0; i < `TRIG_NUM; i++) begin
			entry_sel[i] = (bank_wr.index == tsel_t'(i));
		end
	end

	// --------------------------------------------------
	// storage

	// the three strobes are independent, a tdata1 write
	// outside debug mode keeps the stored dmode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_q <= '0;
		end else begin
			for (int i = 0; i < `TRIG_NUM; i++) begin
				if (entry_sel[i] && bank_wr.wen_tdata1) begin
					cfg_q[i].action <= bank_wr.action;
					cfg_q[i].m <= bank_wr.m;
					cfg_q[i].u <= bank_wr.u;
					cfg_q[i].execute <= bank_wr.execute;
				end
				if (entry_sel[i] && bank_wr.wen_dmode) begin
					cfg_q[i].dmode <= bank_wr.dmode;
				end
				// full word kept, the matcher drops the low bits itself
				if (entry_sel[i] && bank_wr.wen_tdata2) begin
					cfg_q[i].tdata2 <= bank_wr.tdata2;
				end
			end
		end
	end

	// --------------------------------------------------
	// read ports

	// selected entry for CSR reads and the dmode write check
	assign sel_cfg = cfg_q[bank_wr.index];

	// whole bank for the address matcher
	assign all_cfg = cfg_q;

endmodule

// File: hw/trig_csr_ctrl.sv
// CSR front end of the trigger unit: decodes accesses, holds tselect, guards writes, builds read data
`timescale 1ns/10ps

`include "trig_defines.svh"

module trig_csr_ctrl (
	input logic clk,
	input logic rst_n,
	input trig_pkg::cfg_req_t cfg,
	input logic x_d_mode,
	input trig_pkg::trig_cfg_t sel_cfg,
	output trig_pkg::bank_wr_t bank_wr,
	output trig_pkg::xlen_t cfg_rdata
);

	import trig_pkg::*;

	// type field of tdata1, address/data match
	localparam logic [3:0] MCONTROL_TYPE = 4'h2;

	tsel_t tselect;
	logic tsel_in_range;
	logic sel_tselect;
	logic sel_tdata1;
	logic sel_tdata2;
	logic wr_ok;
	xlen_t tdata1_rd;

	// --------------------------------------------------
	// address decode

	assign sel_tselect = (cfg.addr == `CSR_TSELECT);
	assign sel_tdata1 = (cfg.addr == `CSR_TDATA1);
	assign sel_tdata2 = (cfg.addr == `CSR_TDATA2);

	// widen before comparing so a partly filled index space works too
	assign tsel_in_range = (32'(tselect) < `TRIG_NUM);

	// --------------------------------------------------
	// tselect register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tselect <= '0;
		end else if (cfg.wen && sel_tselect) begin
			tselect <= cfg.wdata[`TRIG_TSEL_W-1:0];
		end
	end

	// --------------------------------------------------
	// write protection and bank strobes

	// a trigger owned by debug mode is silently left alone outside debug mode
	assign wr_ok = cfg.wen && tsel_in_range && (!sel_cfg.dmode || x_d_mode);

	// the bank always points at tselect, which also selects the read entry
	assign bank_wr.index = tselect;
	assign bank_wr.wen_tdata1 = wr_ok && sel_tdata1;
	assign bank_wr.wen_tdata2 = wr_ok && sel_tdata2;
	// dmode can only move while the core sits in debug mode
	assign bank_wr.wen_dmode = wr_ok && sel_tdata1 && x_d_mode;

	// field positions follow the mcontrol layout
	assign bank_wr.dmode = cfg.wdata[27];
	assign bank_wr.action = cfg.wdata[12];
	assign bank_wr.m = cfg.wdata[6];
	assign bank_wr.u = cfg.wdata[3];
	assign bank_wr.execute = cfg.wdata[2];
	assign bank_wr.tdata2 = cfg.wdata;

	// --------------------------------------------------
	// read data

	// mcontrol view of the selected trigger
	// maskmax, hit, select, timing, sizelo, chain, match, s, store, load all zero
	always_comb begin
		tdata1_rd = '0;
		tdata1_rd[`TRIG_XLEN-1 -: 4] = MCONTROL_TYPE;
		tdata1_rd[27] = sel_cfg.dmode;
		tdata1_rd[12] = sel_cfg.action;
		tdata1_rd[6] = sel_cfg.m;
		tdata1_rd[3] = sel_cfg.u;
		tdata1_rd[2] = sel_cfg.execute;
	end

	always_comb begin
		cfg_rdata = '0;
		case (cfg.addr)
			`CSR_TSELECT: begin
				cfg_rdata = xlen_t'(tselect);
			end
			`CSR_TDATA1: begin
				// nonexistent trigger reads as type 0
				if (tsel_in_range) begin
					cfg_rdata = tdata1_rd;
				end
			end
			`CSR_TDATA2: begin
				if (tsel_in_range) begin
					cfg_rdata = sel_cfg.tdata2;
				end
			end
			`CSR_TINFO: begin
				cfg_rdata = tsel_in_range ? xlen_t'(`TINFO_MCONTROL) : xlen_t'(`TINFO_NONE);
			end
			default: begin
				// unknown CSR numbers read zero
				cfg_rdata = '0;
			end
		endcase
	end

endmodule

// File: hw/trig_pkg.sv
// shared types of the trigger unit, imported by every RTL module and the testbench

`include "trig_defines.svh"

package trig_pkg;

	// --------------------------------------------------
	// plain vector types

	// data or address word
	typedef logic [`TRIG_XLEN-1:0] xlen_t;
	// CSR number
	typedef logic [11:0] csr_addr_t;
	// trigger index as held in tselect
	typedef logic [`TRIG_TSEL_W-1:0] tsel_t;
	// one flag per halfword of the fetch word, bit 0 is the low halfword
	typedef logic [1:0] hw_flags_t;

	// --------------------------------------------------
	// bundles

	// state of one trigger, the mcontrol bits kept plus the match address
	typedef struct packed {
		logic dmode;
		logic action;
		logic m;
		logic u;
		logic execute;
		xlen_t tdata2;
	} trig_cfg_t;

	// one CSR access, a read every cycle and a write when wen is high
	typedef struct packed {
		csr_addr_t addr;
		logic wen;
		xlen_t wdata;
	} cfg_req_t;

	// one word-aligned fetch with the privilege it is made in
	typedef struct packed {
		xlen_t addr;
		logic m_mode;
		logic d_mode;
	} fetch_query_t;

	// write command to the bank, already checked for range and dmode
	typedef struct packed {
		tsel_t index;
		logic wen_tdata1;
		logic wen_tdata2;
		logic wen_dmode;
		logic dmode;
		logic action;
		logic m;
		logic u;
		logic execute;
		xlen_t tdata2;
	} bank_wr_t;

	// break request per halfword
	// any covers both kinds, d_mode only the debug-mode breaks
	typedef struct packed {
		hw_flags_t any;
		hw_flags_t d_mode;
	} break_req_t;

endpackage

// File: hw/trig_defines.svh
// trigger unit constants (counts, widths, CSR numbers, tinfo codes), included by package and RTL
`ifndef TRIG_DEFINES_SVH
`define TRIG_DEFINES_SVH

// --------------------------------------------------
// sizing

// number of breakpoint triggers implemented
`define TRIG_NUM 4
// data and address width of the core
`define TRIG_XLEN 32
// tselect register width, enough to index every trigger
`define TRIG_TSEL_W 2

// --------------------------------------------------
// debug CSR numbers

`define CSR_TSELECT 12'h7a0
`define CSR_TDATA1 12'h7a1
`define CSR_TDATA2 12'h7a2
`define CSR_TINFO 12'h7a4

// --------------------------------------------------
// tinfo read values

// bit 0 set, no trigger at this index
`define TINFO_NONE 1
// bit 2 set, address/data match (mcontrol)
`define TINFO_MCONTROL 4

`endif
